// ==== include/tcm_settings.svh ====
// tightly coupled data memory settings for sizes and register offsets.
`ifndef TCM_SETTINGS_SVH
`define TCM_SETTINGS_SVH

// the RAM holds 1024 words of 32 bits.
`define TCM_AW 10
`define TCM_DW 32

// number of byte lanes in one word.
`define TCM_NB 4

// byte addresses carry two extra bits for the lane offset.
`define TCM_BAW (`TCM_AW + 2)

// the configuration bus decodes a 3-bit register address.
`define TCM_CFG_AW 3

// register offsets of the block-move engine.
`define TCM_REG_CTRL   3'd0
`define TCM_REG_SRC    3'd1
`define TCM_REG_DST    3'd2
`define TCM_REG_LEN    3'd3
`define TCM_REG_FILL   3'd4
`define TCM_REG_STATUS 3'd5

`endif

// ==== rtl/tcm_pkg.sv ====
// tightly coupled memory types for the load/store unit and the block-move engine.
`include "tcm_settings.svh"

package tcm_pkg;

   // load/store opcodes.
   // loads come first so that bit 2 alone never decides the direction.
   typedef enum logic [2:0] {
      OP_LB,
      OP_LBU,
      OP_LH,
      OP_LHU,
      OP_LW,
      OP_SB,
      OP_SH,
      OP_SW
   } lsu_op_e;

   // the engine either writes a pattern or moves words.
   typedef enum logic {
      MODE_FILL,
      MODE_COPY
   } dma_mode_e;

   // engine FSM states.
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_READ,
      ST_WRITE,
      ST_FILL
   } dma_state_e;

   // engine configuration as held by the register block.
   // addresses and length are counted in words.
   typedef struct packed {
      logic [`TCM_AW-1:0] src;
      logic [`TCM_AW-1:0] dst;
      logic [`TCM_AW:0]   len;
      dma_mode_e          mode;
      logic [`TCM_DW-1:0] fill;
   } dma_cfg_t;

endpackage

// ==== rtl/tcm_mem_if.sv ====
// one RAM port bundle between a requester and the dual-port memory.
`timescale 1ns/1ps
`include "tcm_settings.svh"

interface tcm_mem_if;

   // access enable, one cycle per access.
   logic                en;
   // byte write mask, all zero for a read.
   logic [`TCM_NB-1:0]  we;
   // word address.
   logic [`TCM_AW-1:0]  addr;
   logic [`TCM_DW-1:0]  wdata;
   // registered read data, valid the cycle after an enabled edge.
   logic [`TCM_DW-1:0]  rdata;

   // the requester issues accesses and takes the returned word.
   modport requester (
      output en,
      output we,
      output addr,
      output wdata,
      input  rdata
   );

   // the memory side of the same port.
   modport ram (
      input  en,
      input  we,
      input  addr,
      input  wdata,
      output rdata
   );

endinterface

// ==== rtl/tcm_dpram.sv ====
// true dual-port read-first RAM with byte write enables on a single clock.
`timescale 1ns/1ps
`include "tcm_settings.svh"

module tcm_dpram #(
   parameter int AW = `TCM_AW,
   parameter int DW = `TCM_DW
) (
   input logic       clk_a,
   tcm_mem_if.ram    port_a,
   tcm_mem_if.ram    port_b
);

   localparam int NB = DW / 8;
   localparam int DEPTH = 1 << AW;

   // the storage array is shared by both ports.
   logic [DW-1:0] mem_q [DEPTH];

   // read registers keep their value while the port is idle.
   logic [DW-1:0] dout_a_q = '0;
   logic [DW-1:0] dout_b_q = '0;

   // the array starts out cleared in simulation.
   initial begin
      for (int k = 0; k < DEPTH; k++) begin
         mem_q[k] = '0;
      end
   end

   // both ports share one process so the array has a single writer.
   // all reads sample the array before any write at this edge lands,
   // which gives read-first behaviour across both ports.
   always @(posedge clk_a) begin
      if (port_a.en) begin
         for (int i = 0; i < NB; i++) begin
            if (port_a.we[i]) begin
               mem_q[port_a.addr][8*i +: 8] <= port_a.wdata[8*i +: 8];
            end
         end
         dout_a_q <= mem_q[port_a.addr];
      end
      if (port_b.en) begin
         for (int j = 0; j < NB; j++) begin
            if (port_b.we[j]) begin
               mem_q[port_b.addr][8*j +: 8] <= port_b.wdata[8*j +: 8];
            end
         end
         dout_b_q <= mem_q[port_b.addr];
      end
   end

   assign port_a.rdata = dout_a_q;
   assign port_b.rdata = dout_b_q;

   // the load/store unit and the block-move engine must never write the
   // same byte of the same word in one cycle, since the result is undefined.
   a_no_byte_collision : assert property (@(posedge clk_a)
      !(port_a.en && port_b.en && (port_a.addr == port_b.addr)
        && |(port_a.we & port_b.we)))
      else $error("both RAM ports write the same byte in one cycle");

endmodule

// ==== rtl/tcm_lsu.sv ====
// load/store unit driving RAM port A with lane placement, load extension and alignment checks.
`timescale 1ns/1ps
`include "tcm_settings.svh"

module tcm_lsu (
   input  logic                clk_a,
   input  logic                arst_n,
   input  logic                lsu_req,
   input  tcm_pkg::lsu_op_e    lsu_op,
   input  logic [`TCM_BAW-1:0] lsu_addr,
   input  logic [`TCM_DW-1:0]  lsu_wdata,
   output logic                lsu_rvalid,
   output logic [`TCM_DW-1:0]  lsu_rdata,
   output logic                lsu_err,
   tcm_mem_if.requester        mem
);

   import tcm_pkg::*;

   logic               is_store;
   logic               misaligned;
   logic [`TCM_NB-1:0] lane_mask;
   logic [1:0]         offset;
   logic               ld_q;
   logic               err_q;
   lsu_op_e            op_q;
   logic [1:0]         off_q;
   logic [7:0]         byte_sel;
   logic [15:0]        half_sel;
   logic [`TCM_DW-1:0] load_ext;

   assign offset = lsu_addr[1:0];

   // decode the access size into a lane mask and an alignment check.
   // halfwords need bit 0 clear and words need both low bits clear.
   always_comb begin
      is_store   = 1'b0;
      misaligned = 1'b0;
      lane_mask  = 4'b1111;
      case (lsu_op)
         OP_SB, OP_LB, OP_LBU: begin
            lane_mask = 4'b0001 << offset;
         end
         OP_SH, OP_LH, OP_LHU: begin
            lane_mask  = 4'b0011 << offset;
            misaligned = offset[0];
         end
         default: begin
            misaligned = |offset;
         end
      endcase
      is_store = (lsu_op == OP_SB) || (lsu_op == OP_SH) || (lsu_op == OP_SW);
   end

   // a misaligned request never reaches the RAM.
   assign mem.en   = lsu_req && !misaligned;
   assign mem.we   = is_store ? lane_mask : '0;
   assign mem.addr = lsu_addr[`TCM_BAW-1:2];

   // store data is copied to every lane and the mask picks the live ones.
   always_comb begin
      case (lsu_op)
         OP_SB:   mem.wdata = {4{lsu_wdata[7:0]}};
         OP_SH:   mem.wdata = {2{lsu_wdata[15:0]}};
         default: mem.wdata = lsu_wdata;
      endcase
   end

   // first stage tracks the access while the RAM reads.
   // the opcode and offset are kept so the returned word can be sliced.
   always_ff @(posedge clk_a or negedge arst_n) begin
      if (!arst_n) begin
         ld_q  <= 1'b0;
         err_q <= 1'b0;
         op_q  <= OP_LB;
         off_q <= 2'b00;
      end else begin
         ld_q  <= lsu_req && !is_store && !misaligned;
         err_q <= lsu_req && misaligned;
         op_q  <= lsu_op;
         off_q <= offset;
      end
   end

   // pick the addressed byte and halfword out of the returned word.
   always_comb begin
      case (off_q)
         2'd0:    byte_sel = mem.rdata[7:0];
         2'd1:    byte_sel = mem.rdata[15:8];
         2'd2:    byte_sel = mem.rdata[23:16];
         default: byte_sel = mem.rdata[31:24];
      endcase
      half_sel = off_q[1] ? mem.rdata[31:16] : mem.rdata[15:0];
   end

   // sign or zero extension follows the stored opcode.
   always_comb begin
      case (op_q)
         OP_LB:   load_ext = {{24{byte_sel[7]}}, byte_sel};
         OP_LBU:  load_ext = {24'd0, byte_sel};
         OP_LH:   load_ext = {{16{half_sel[15]}}, half_sel};
         OP_LHU:  load_ext = {16'd0, half_sel};
         default: load_ext = mem.rdata;
      endcase
   end

   // second stage registers the response, one cycle after the RAM edge.
   always_ff @(posedge clk_a or negedge arst_n) begin
      if (!arst_n) begin
         lsu_rvalid <= 1'b0;
         lsu_err    <= 1'b0;
         lsu_rdata  <= '0;
      end else begin
         lsu_rvalid <= ld_q;
         lsu_err    <= err_q;
         if (ld_q) begin
            lsu_rdata <= load_ext;
         end
      end
   end

   // a request is either served or rejected, never both.
   a_rvalid_err_excl : assert property (@(posedge clk_a) disable iff (!arst_n)
      !(lsu_rvalid && lsu_err))
      else $error("load response and misalignment error raised together");

endmodule

// ==== rtl/tcm_dma_regs.sv ====
// configuration and status registers of the block-move engine.
`timescale 1ns/1ps
`include "tcm_settings.svh"

module tcm_dma_regs (
   input  logic                   clk_a,
   input  logic                   arst_n,
   input  logic                   cfg_wr,
   input  logic                   cfg_rd,
   input  logic [`TCM_CFG_AW-1:0] cfg_addr,
   input  logic [`TCM_DW-1:0]     cfg_wdata,
   input  logic                   busy,
   input  logic                   done,
   output logic [`TCM_DW-1:0]     cfg_rdata,
   output tcm_pkg::dma_cfg_t      cfg,
   output logic                   start,
   output logic                   done_sticky
);

   import tcm_pkg::*;

   dma_cfg_t           cfg_q;
   logic               start_q;
   logic               locked;
   logic               wr_ok;
   logic [`TCM_DW-1:0] rd_mux;

   // the start pulse is still in flight for one cycle before the engine
   // reports busy, so that cycle counts as busy too.
   assign locked = busy || start_q;
   assign wr_ok  = cfg_wr && !locked;

   always_ff @(posedge clk_a or negedge arst_n) begin
      if (!arst_n) begin
         cfg_q       <= '0;
         start_q     <= 1'b0;
         done_sticky <= 1'b0;
         cfg_rdata   <= '0;
      end else begin
         start_q <= 1'b0;
         if (done) begin
            done_sticky <= 1'b1;
         end
         if (wr_ok) begin
            case (cfg_addr)
               `TCM_REG_CTRL: begin
                  cfg_q.mode <= dma_mode_e'(cfg_wdata[1]);
                  // an accepted start clears the previous done.
                  if (cfg_wdata[0]) begin
                     start_q     <= 1'b1;
                     done_sticky <= 1'b0;
                  end
               end
               `TCM_REG_SRC:  cfg_q.src  <= cfg_wdata[`TCM_AW-1:0];
               `TCM_REG_DST:  cfg_q.dst  <= cfg_wdata[`TCM_AW-1:0];
               `TCM_REG_LEN:  cfg_q.len  <= cfg_wdata[`TCM_AW:0];
               `TCM_REG_FILL: cfg_q.fill <= cfg_wdata;
               default: ;
            endcase
         end
         if (cfg_rd) begin
            cfg_rdata <= rd_mux;
         end
      end
   end

   // read mux, fields sit right-aligned and unused bits read as zero.
   always_comb begin
      rd_mux = '0;
      case (cfg_addr)
         `TCM_REG_CTRL:   rd_mux[1] = cfg_q.mode;
         `TCM_REG_SRC:    rd_mux[`TCM_AW-1:0] = cfg_q.src;
         `TCM_REG_DST:    rd_mux[`TCM_AW-1:0] = cfg_q.dst;
         `TCM_REG_LEN:    rd_mux[`TCM_AW:0] = cfg_q.len;
         `TCM_REG_FILL:   rd_mux = cfg_q.fill;
         `TCM_REG_STATUS: rd_mux[1:0] = {done_sticky, locked};
         default: ;
      endcase
   end

   assign cfg   = cfg_q;
   assign start = start_q;

endmodule

// ==== rtl/tcm_dma.sv ====
// block-move engine filling or copying word ranges through RAM port B.
`timescale 1ns/1ps
`include "tcm_settings.svh"

module tcm_dma (
   input  logic              clk_a,
   input  logic              arst_n,
   input  tcm_pkg::dma_cfg_t cfg,
   input  logic              start,
   output logic              busy,
   output logic              done,
   tcm_mem_if.requester      mem
);

   import tcm_pkg::*;

   dma_state_e         state_q;
   logic [`TCM_AW-1:0] src_q;
   logic [`TCM_AW-1:0] dst_q;
   logic [`TCM_AW:0]   cnt_q;
   logic [`TCM_DW-1:0] fill_q;
   logic               done_q;
   logic               last;

   // the current word is the final one of the run.
   assign last = (cnt_q == 1);

   always_ff @(posedge clk_a or negedge arst_n) begin
      if (!arst_n) begin
         state_q <= ST_IDLE;
         src_q   <= '0;
         dst_q   <= '0;
         cnt_q   <= '0;
         fill_q  <= '0;
         done_q  <= 1'b0;
      end else begin
         done_q <= 1'b0;
         case (state_q)
            ST_IDLE: begin
               // the configuration is captured so later register writes
               // cannot disturb a run.
               if (start) begin
                  src_q  <= cfg.src;
                  dst_q  <= cfg.dst;
                  cnt_q  <= cfg.len;
                  fill_q <= cfg.fill;
                  if (cfg.len == 0) begin
                     done_q <= 1'b1;
                  end else if (cfg.mode == MODE_FILL) begin
                     state_q <= ST_FILL;
                  end else begin
                     state_q <= ST_READ;
                  end
               end
            end
            ST_FILL: begin
               // one pattern word per cycle.
               dst_q <= dst_q + 1'b1;
               cnt_q <= cnt_q - 1'b1;
               if (last) begin
                  state_q <= ST_IDLE;
                  done_q  <= 1'b1;
               end
            end
            ST_READ: begin
               src_q   <= src_q + 1'b1;
               state_q <= ST_WRITE;
            end
            ST_WRITE: begin
               // the word read in the previous cycle is being written now.
               dst_q <= dst_q + 1'b1;
               cnt_q <= cnt_q - 1'b1;
               if (last) begin
                  state_q <= ST_IDLE;
                  done_q  <= 1'b1;
               end else begin
                  state_q <= ST_READ;
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // port B drive follows the state directly.
   always_comb begin
      mem.en    = 1'b0;
      mem.we    = '0;
      mem.addr  = dst_q;
      mem.wdata = fill_q;
      case (state_q)
         ST_FILL: begin
            mem.en = 1'b1;
            mem.we = '1;
         end
         ST_READ: begin
            mem.en   = 1'b1;
            mem.addr = src_q;
         end
         ST_WRITE: begin
            mem.en    = 1'b1;
            mem.we    = '1;
            mem.wdata = mem.rdata;
         end
         default: ;
      endcase
   end

   assign busy = (state_q != ST_IDLE);
   assign done = done_q;

   // an idle engine leaves port B alone.
   a_idle_no_access : assert property (@(posedge clk_a) disable iff (!arst_n)
      (state_q == ST_IDLE) |-> !mem.en)
      else $error("block-move engine accesses the RAM while idle");

endmodule

// ==== rtl/tcm_top.sv ====
// tightly coupled data memory top level with load/store and block-move ports.
`timescale 1ns/1ps
`include "tcm_settings.svh"

module tcm_top (
   input  logic                   clk_a,
   input  logic                   arst_n,
   // load/store side.
   input  logic                   lsu_req,
   input  tcm_pkg::lsu_op_e       lsu_op,
   input  logic [`TCM_BAW-1:0]    lsu_addr,
   input  logic [`TCM_DW-1:0]     lsu_wdata,
   output logic                   lsu_rvalid,
   output logic [`TCM_DW-1:0]     lsu_rdata,
   output logic                   lsu_err,
   // configuration side of the block-move engine.
   input  logic                   cfg_wr,
   input  logic                   cfg_rd,
   input  logic [`TCM_CFG_AW-1:0] cfg_addr,
   input  logic [`TCM_DW-1:0]     cfg_wdata,
   output logic [`TCM_DW-1:0]     cfg_rdata,
   output logic                   dma_done
);

   import tcm_pkg::*;

   dma_cfg_t dma_cfg;
   logic     dma_start;
   logic     dma_busy;

   // port A belongs to the load/store unit and port B to the engine.
   tcm_mem_if if_a ();
   tcm_mem_if if_b ();

   tcm_dpram #(
      .AW (`TCM_AW),
      .DW (`TCM_DW)
   ) u_ram (
      .clk_a  (clk_a),
      .port_a (if_a.ram),
      .port_b (if_b.ram)
   );

   tcm_lsu u_lsu (
      .clk_a      (clk_a),
      .arst_n     (arst_n),
      .lsu_req    (lsu_req),
      .lsu_op     (lsu_op),
      .lsu_addr   (lsu_addr),
      .lsu_wdata  (lsu_wdata),
      .lsu_rvalid (lsu_rvalid),
      .lsu_rdata  (lsu_rdata),
      .lsu_err    (lsu_err),
      .mem        (if_a.requester)
   );

   tcm_dma_regs u_regs (
      .clk_a       (clk_a),
      .arst_n      (arst_n),
      .cfg_wr      (cfg_wr),
      .cfg_rd      (cfg_rd),
      .cfg_addr    (cfg_addr),
      .cfg_wdata   (cfg_wdata),
      .busy        (dma_busy),
      .done        (dma_done),
      .cfg_rdata   (cfg_rdata),
      .cfg         (dma_cfg),
      .start       (dma_start),
      .done_sticky ()
   );

   tcm_dma u_dma (
      .clk_a  (clk_a),
      .arst_n (arst_n),
      .cfg    (dma_cfg),
      .start  (dma_start),
      .busy   (dma_busy),
      .done   (dma_done),
      .mem    (if_b.requester)
   );

endmodule

// ==== verif/tcm_tb.sv ====
// self-checking testbench for the tightly coupled memory with a byte-level memory model.
`timescale 1ns/1ps
`include "tcm_settings.svh"

module tcm_tb;

   import tcm_pkg::*;

   // the summed length of all tests stays below this many cycles.
   localparam int TEST_CYCLES    = 5000;
   localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;

   logic                   clk_a;
   logic                   arst_n;
   logic                   lsu_req;
   lsu_op_e                lsu_op;
   logic [`TCM_BAW-1:0]    lsu_addr;
   logic [`TCM_DW-1:0]     lsu_wdata;
   logic                   lsu_rvalid;
   logic [`TCM_DW-1:0]     lsu_rdata;
   logic                   lsu_err;
   logic                   cfg_wr;
   logic                   cfg_rd;
   logic [`TCM_CFG_AW-1:0] cfg_addr;
   logic [`TCM_DW-1:0]     cfg_wdata;
   logic [`TCM_DW-1:0]     cfg_rdata;
   logic                   dma_done;

   // byte image of the RAM where lane k of word w sits at byte address 4*w+k.
   logic [7:0]  mem_model [1 << `TCM_BAW];
   // expected port A responses in issue order with bit 32 marking a misalignment error.
   logic [32:0] exp_q [$];
   logic [32:0] resp_exp;
   logic [31:0] rng_state;
   int          errors;
   int          checks_run;
   int          done_seen;
   int          runs;
   int          cycles;

   tcm_top u_tcm_top (
      .clk_a      (clk_a),
      .arst_n     (arst_n),
      .lsu_req    (lsu_req),
      .lsu_op     (lsu_op),
      .lsu_addr   (lsu_addr),
      .lsu_wdata  (lsu_wdata),
      .lsu_rvalid (lsu_rvalid),
      .lsu_rdata  (lsu_rdata),
      .lsu_err    (lsu_err),
      .cfg_wr     (cfg_wr),
      .cfg_rd     (cfg_rd),
      .cfg_addr   (cfg_addr),
      .cfg_wdata  (cfg_wdata),
      .cfg_rdata  (cfg_rdata),
      .dma_done   (dma_done)
   );

   // 4 ns clock period.
   always #2 clk_a = ~clk_a;

   // xorshift generator whose state lives in rng_state.
   function automatic logic [31:0] next_rand();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   // halfwords need bit 0 clear and words need both low bits clear.
   function automatic logic is_misaligned(lsu_op_e op, logic [`TCM_BAW-1:0] addr);
      case (op)
         OP_LH, OP_LHU, OP_SH: return addr[0];
         OP_LW, OP_SW:         return addr[1:0] != 2'b00;
         default:              return 1'b0;
      endcase
   endfunction

   function automatic logic [`TCM_BAW-1:0] word_addr(int w);
      return {w[`TCM_AW-1:0], 2'b00};
   endfunction

   function automatic logic [31:0] model_word(int w);
      return {mem_model[4*w+3], mem_model[4*w+2], mem_model[4*w+1], mem_model[4*w]};
   endfunction

   function automatic void set_model_word(int w, logic [31:0] v);
      for (int k = 0; k < 4; k++) begin
         mem_model[4*w+k] = v[8*k +: 8];
      end
   endfunction

   // the expected load value is little endian with sign or zero extension by opcode.
   function automatic logic [31:0] ref_load(lsu_op_e op, logic [`TCM_BAW-1:0] addr);
      logic [7:0]  b;
      logic [15:0] h;
      b = mem_model[addr];
      h = {mem_model[addr + 1'b1], mem_model[addr]};
      case (op)
         OP_LB:   return {{24{b[7]}}, b};
         OP_LBU:  return {24'd0, b};
         OP_LH:   return {{16{h[15]}}, h};
         OP_LHU:  return {16'd0, h};
         default: return model_word(int'(addr[`TCM_BAW-1:2]));
      endcase
   endfunction

   function automatic void model_store(lsu_op_e op, logic [`TCM_BAW-1:0] addr,
                                       logic [31:0] data);
      mem_model[addr] = data[7:0];
      if (op != OP_SB) begin
         mem_model[addr + 1'b1] = data[15:8];
      end
      if (op == OP_SW) begin
         mem_model[addr + 2'd2] = data[23:16];
         mem_model[addr + 2'd3] = data[31:24];
      end
   endfunction

   // the single compare point of the testbench.
   task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
      checks_run++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t ns: %s got %08h expected %08h", $time, what, got, exp);
      end
   endtask

   // each call holds one request for one cycle and updates the model in issue order.
   task automatic lsu_issue(input lsu_op_e op, input logic [`TCM_BAW-1:0] addr,
                            input logic [31:0] data);
      @(negedge clk_a);
      lsu_req   = 1'b1;
      lsu_op    = op;
      lsu_addr  = addr;
      lsu_wdata = data;
      if (is_misaligned(op, addr)) begin
         exp_q.push_back({1'b1, 32'd0});
      end else if (op inside {OP_SB, OP_SH, OP_SW}) begin
         model_store(op, addr, data);
      end else begin
         exp_q.push_back({1'b0, ref_load(op, addr)});
      end
   endtask

   // stop requesting and wait until every expected response has come back.
   task automatic lsu_drain();
      @(negedge clk_a);
      lsu_req = 1'b0;
      while (exp_q.size() != 0) begin
         @(negedge clk_a);
      end
   endtask

   task automatic reg_write(input logic [2:0] addr, input logic [31:0] data);
      @(negedge clk_a);
      cfg_wr    = 1'b1;
      cfg_addr  = addr;
      cfg_wdata = data;
      @(negedge clk_a);
      cfg_wr = 1'b0;
   endtask

   // read data is registered, so it is taken one cycle after the strobe.
   task automatic reg_read(input logic [2:0] addr, output logic [31:0] data);
      @(negedge clk_a);
      cfg_rd   = 1'b1;
      cfg_addr = addr;
      @(negedge clk_a);
      cfg_rd = 1'b0;
      data   = cfg_rdata;
   endtask

   task automatic start_run(input int src, input int dst, input int len,
                            input logic [31:0] pat, input dma_mode_e mode);
      reg_write(`TCM_REG_SRC, src);
      reg_write(`TCM_REG_DST, dst);
      reg_write(`TCM_REG_LEN, len);
      reg_write(`TCM_REG_FILL, pat);
      reg_write(`TCM_REG_CTRL, {30'd0, mode == MODE_COPY, 1'b1});
      runs++;
   endtask

   // the done monitor counts pulses, so a wait never misses one.
   task automatic wait_done();
      wait (done_seen >= runs);
      @(negedge clk_a);
   endtask

   task automatic report(input string name, input int err_before);
      $display("test %s finished with %0d errors", name, errors - err_before);
   endtask

   always @(negedge clk_a) begin
      if (dma_done) begin
         done_seen++;
      end
   end

   // every port A response is matched against the oldest expected entry.
   always @(negedge clk_a) begin
      if (lsu_rvalid || lsu_err) begin
         if (exp_q.size() == 0) begin
            errors++;
            $display("a load/store response came at %0t ns with nothing outstanding", $time);
         end else begin
            resp_exp = exp_q.pop_front();
            check("response is an error", {31'd0, lsu_err}, {31'd0, resp_exp[32]});
            if (!resp_exp[32]) begin
               check("load data", lsu_rdata, resp_exp[31:0]);
            end
         end
      end
   end

   always @(posedge clk_a) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   initial begin
      logic [31:0]         r;
      logic [31:0]         pat;
      logic [31:0]         rd;
      lsu_op_e             op;
      logic [`TCM_BAW-1:0] a;
      int                  e0;
      int                  src;
      int                  dst;
      int                  len;
      clk_a      = 1'b0;
      arst_n     = 1'b0;
      lsu_req    = 1'b0;
      lsu_op     = OP_LB;
      lsu_addr   = '0;
      lsu_wdata  = '0;
      cfg_wr     = 1'b0;
      cfg_rd     = 1'b0;
      cfg_addr   = '0;
      cfg_wdata  = '0;
      rng_state  = 32'h5a8d1002;
      errors     = 0;
      checks_run = 0;
      done_seen  = 0;
      runs       = 0;
      cycles     = 0;
      // the RAM starts cleared, so the model does too.
      for (int i = 0; i < (1 << `TCM_BAW); i++) begin
         mem_model[i] = 8'd0;
      end
      repeat (3) @(posedge clk_a);
      @(negedge clk_a);
      arst_n = 1'b1;

      // random traffic confined to words 0 to 63 so loads hit stored data.
      e0 = errors;
      repeat (200) begin
         r  = next_rand();
         op = lsu_op_e'(r[2:0]);
         a  = {4'd0, r[13:8], 2'b00};
         case (op)
            OP_SB, OP_LB, OP_LBU: a[1:0] = r[15:14];
            OP_SH, OP_LH, OP_LHU: a[1] = r[14];
            default: ;
         endcase
         lsu_issue(op, a, next_rand());
      end
      lsu_drain();
      report("random_loads_stores", e0);

      // byte and halfword stores merge into word 100.
      e0 = errors;
      lsu_issue(OP_SW, 12'd400, 32'h11223344);
      lsu_issue(OP_SB, 12'd401, 32'h000000ab);
      lsu_issue(OP_SH, 12'd402, 32'h0000cdef);
      lsu_issue(OP_LW, 12'd400, '0);
      lsu_issue(OP_LB, 12'd401, '0);
      lsu_issue(OP_LBU, 12'd401, '0);
      lsu_issue(OP_LH, 12'd402, '0);
      lsu_issue(OP_LHU, 12'd402, '0);
      lsu_drain();
      report("byte_lane_merge", e0);

      // misaligned accesses around word 120 must leave it untouched.
      e0 = errors;
      lsu_issue(OP_SW, 12'd480, 32'ha5a55a5a);
      lsu_issue(OP_SH, 12'd481, 32'h00001234);
      lsu_issue(OP_SW, 12'd482, 32'hffffffff);
      lsu_issue(OP_LH, 12'd483, '0);
      lsu_issue(OP_LW, 12'd481, '0);
      lsu_issue(OP_LW, 12'd480, '0);
      lsu_drain();
      report("misaligned", e0);

      // fill a random range and read one word beyond each end.
      e0 = errors;
      r   = next_rand();
      dst = 200 + int'(r[5:0]);
      len = 1 + int'(r[11:6]) % 48;
      pat = next_rand();
      start_run(0, dst, len, pat, MODE_FILL);
      wait_done();
      for (int i = 0; i < len; i++) begin
         set_model_word(dst + i, pat);
      end
      for (int w = dst - 1; w <= dst + len; w++) begin
         lsu_issue(OP_LW, word_addr(w), '0);
      end
      lsu_drain();
      report("fill", e0);

      // copy 256 words from the random traffic region to the upper half.
      e0 = errors;
      r   = next_rand();
      src = int'(r[5:0]);
      dst = 512 + int'(r[12:6]);
      start_run(src, dst, 256, '0, MODE_COPY);
      wait_done();
      for (int i = 0; i < 256; i++) begin
         set_model_word(dst + i, model_word(src + i));
      end
      for (int w = dst; w < dst + 256; w++) begin
         lsu_issue(OP_LW, word_addr(w), '0);
      end
      lsu_drain();
      report("copy", e0);

      // registers are read back before writes and a second start arrive during a run.
      e0 = errors;
      reg_write(`TCM_REG_SRC, 32'h155);
      reg_write(`TCM_REG_DST, 32'h2aa);
      reg_write(`TCM_REG_LEN, 32'h7ff);
      reg_write(`TCM_REG_FILL, 32'h0f1e2d3c);
      reg_write(`TCM_REG_CTRL, 32'h2);
      reg_read(`TCM_REG_SRC, rd);
      check("SRC read-back", rd, 32'h155);
      reg_read(`TCM_REG_DST, rd);
      check("DST read-back", rd, 32'h2aa);
      reg_read(`TCM_REG_LEN, rd);
      check("LEN read-back", rd, 32'h7ff);
      reg_read(`TCM_REG_FILL, rd);
      check("FILL read-back", rd, 32'h0f1e2d3c);
      reg_read(`TCM_REG_CTRL, rd);
      check("CTRL read-back", rd, 32'h2);
      pat = next_rand();
      start_run(0, 900, 64, pat, MODE_FILL);
      reg_read(`TCM_REG_STATUS, rd);
      check("STATUS while busy", rd, 32'h1);
      reg_write(`TCM_REG_CTRL, 32'h3);
      reg_write(`TCM_REG_FILL, ~pat);
      reg_write(`TCM_REG_LEN, 32'h5);
      reg_read(`TCM_REG_FILL, rd);
      check("FILL kept while busy", rd, pat);
      reg_read(`TCM_REG_LEN, rd);
      check("LEN kept while busy", rd, 32'd64);
      reg_read(`TCM_REG_CTRL, rd);
      check("CTRL kept while busy", rd, 32'h0);
      reg_read(`TCM_REG_STATUS, rd);
      check("STATUS still busy", rd, 32'h1);
      wait_done();
      repeat (4) @(negedge clk_a);
      reg_read(`TCM_REG_STATUS, rd);
      check("STATUS after run", rd, 32'h2);
      check("done pulse count", done_seen, runs);
      for (int i = 0; i < 64; i++) begin
         set_model_word(900 + i, pat);
      end
      for (int w = 899; w <= 964; w++) begin
         lsu_issue(OP_LW, word_addr(w), '0);
      end
      lsu_drain();
      report("registers_while_busy", e0);

      $display("tests run 6, checks %0d, errors %0d", checks_run, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// ==== tcm_top.f ====
+incdir+include
rtl/tcm_pkg.sv
rtl/tcm_mem_if.sv
rtl/tcm_dpram.sv
rtl/tcm_lsu.sv
rtl/tcm_dma_regs.sv
rtl/tcm_dma.sv
rtl/tcm_top.sv
verif/tcm_tb.sv

// ==== Makefile ====
# Verilator build and run of the tightly coupled memory testbench.
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tcm_tb
FILELIST  = tcm_top.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = PASS: all tests

.PHONY: sim clean

# the run passes only when the log holds the pass line.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
